/* design/spw_char_pkg.sv */
// Character-level SpaceWire definitions shared by the transmit FSM, shifter and testbench
package spw_char_pkg;

	// --------------------
	// Character kinds
	// --------------------
	typedef enum logic [2:0]
	{
		NULL,
		FCT,
		DATA,
		EOP,
		EEP
	} char_kind_e;

	typedef logic [7:0] spw_data_t;

	// Bit 8 is the control flag, low bits 00 = EOP and 01 = EEP
	typedef logic [8:0] tx_word_t;

	typedef struct packed
	{
		logic       valid;
		char_kind_e kind;
		spw_data_t  data;
	} char_req_t;

	// --------------------
	// Line patterns
	// --------------------
	// Bits after parity, bit 0 goes out first
	localparam logic [6:0] NULL_BITS = 7'b0010111;
	localparam logic [2:0] FCT_BITS  = 3'b001;
	localparam logic [2:0] EOP_BITS  = 3'b101;
	localparam logic [2:0] EEP_BITS  = 3'b011;
	localparam logic       DATA_FLAG = 1'b0;

	localparam int MAX_CHAR_LEN = 10;

	typedef logic [MAX_CHAR_LEN-1:0] char_word_t;
	typedef logic [$clog2(MAX_CHAR_LEN+1)-1:0] bit_cnt_t;

	// Lengths include the parity bit
	localparam bit_cnt_t NULL_LEN = bit_cnt_t'(8);
	localparam bit_cnt_t FCT_LEN  = bit_cnt_t'(4);
	localparam bit_cnt_t DATA_LEN = bit_cnt_t'(10);
	localparam bit_cnt_t EOP_LEN  = bit_cnt_t'(4);
	localparam bit_cnt_t EEP_LEN  = bit_cnt_t'(4);

endpackage

/* design/spw_link_pkg.sv */
// Link-level SpaceWire definitions: link states, flow-control counters and the DS line pair
package spw_link_pkg;

	typedef enum logic [1:0]
	{
		START,
		SEND_NULL,
		SEND_NULL_FCT,
		RUN
	} link_state_e;

	// --------------------
	// Flow control
	// --------------------
	typedef logic [5:0] credit_t;
	typedef logic [2:0] owed_t;

	// One received FCT opens eight N-char slots
	localparam credit_t CREDIT_STEP = 6'd8;
	localparam credit_t CREDIT_MAX  = 6'd56;

	// Receiver buffer space announced after reset
	localparam owed_t OWED_RESET = 3'd7;
	localparam owed_t OWED_MAX   = 3'd7;

	typedef struct packed
	{
		logic d;
		logic s;
	} ds_line_t;

endpackage

/* design/spw_tx_credit.sv */
// Tracks transmit credit and owed FCTs from edge-detected requests and issued characters
`timescale 1ns/100ps

module spw_tx_credit
(
	input  logic                    pclk_tx,
	input  logic                    enable_tx,
	input  logic                    gotfct_i,
	input  logic                    send_fct_now_i,
	input  spw_char_pkg::char_req_t req_i,
	output spw_link_pkg::credit_t   credit_o,
	output spw_link_pkg::owed_t     owed_o
);

	logic                  gotfct_q;
	logic                  fct_now_q;
	logic                  got_rise;
	logic                  fct_now_rise;
	logic                  nchar_sent;
	logic                  fct_sent;
	logic [6:0]            credit_sum;
	logic [3:0]            owed_sum;
	spw_link_pkg::credit_t credit_q;
	spw_link_pkg::owed_t   owed_q;

	// Each pulse counts once
	assign got_rise     = gotfct_i & ~gotfct_q;
	assign fct_now_rise = send_fct_now_i & ~fct_now_q;

	assign nchar_sent = req_i.valid &&
		(req_i.kind == spw_char_pkg::DATA ||
		 req_i.kind == spw_char_pkg::EOP ||
		 req_i.kind == spw_char_pkg::EEP);
	assign fct_sent = req_i.valid && (req_i.kind == spw_char_pkg::FCT);

	// Add and subtract may land together
	always_comb
	begin
		credit_sum = {1'b0, credit_q}
			+ (got_rise ? {1'b0, spw_link_pkg::CREDIT_STEP} : 7'd0)
			- {6'd0, nchar_sent};
		owed_sum = {1'b0, owed_q} + {3'd0, fct_now_rise} - {3'd0, fct_sent};
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			gotfct_q  <= 1'b0;
			fct_now_q <= 1'b0;
			credit_q  <= '0;
			owed_q    <= spw_link_pkg::OWED_RESET;
		end
		else
		begin
			gotfct_q  <= gotfct_i;
			fct_now_q <= send_fct_now_i;
			if (credit_sum > {1'b0, spw_link_pkg::CREDIT_MAX})
				credit_q <= spw_link_pkg::CREDIT_MAX;
			else
				credit_q <= credit_sum[5:0];
			if (owed_sum > {1'b0, spw_link_pkg::OWED_MAX})
				owed_q <= spw_link_pkg::OWED_MAX;
			else
				owed_q <= owed_sum[2:0];
		end
	end

	assign credit_o = credit_q;
	assign owed_o   = owed_q;

endmodule

/* design/spw_tx_link_fsm.sv */
// Link start-up state machine that picks the next character at every character boundary
`timescale 1ns/100ps

module spw_tx_link_fsm
(
	input  logic                    pclk_tx,
	input  logic                    enable_tx,
	input  logic                    send_null_i,
	input  logic                    send_fct_i,
	input  logic                    txwrite_i,
	input  spw_char_pkg::tx_word_t  data_i,
	input  logic                    next_i,
	input  spw_link_pkg::credit_t   credit_i,
	input  spw_link_pkg::owed_t     owed_i,
	output spw_char_pkg::char_req_t req_o
);

	spw_link_pkg::link_state_e state_q;
	spw_link_pkg::link_state_e state_d;
	spw_char_pkg::char_kind_e  nchar_kind;
	logic                      have_credit;
	logic                      have_owed;

	assign have_credit = (credit_i != '0);
	assign have_owed   = (owed_i != '0);

	// Host word decode
	always_comb
	begin
		if (!data_i[8])
			nchar_kind = spw_char_pkg::DATA;
		else if (data_i[1:0] == 2'b01)
			nchar_kind = spw_char_pkg::EEP;
		else
			nchar_kind = spw_char_pkg::EOP;
	end

	// --------------------
	// Next state and character
	// --------------------
	always_comb
	begin
		state_d    = state_q;
		req_o.kind = spw_char_pkg::NULL;
		req_o.data = data_i[7:0];
		case (state_q)
			spw_link_pkg::START:
			begin
				if (send_null_i)
					state_d = spw_link_pkg::SEND_NULL;
			end
			spw_link_pkg::SEND_NULL:
			begin
				if (send_null_i && send_fct_i)
					state_d = spw_link_pkg::SEND_NULL_FCT;
			end
			spw_link_pkg::SEND_NULL_FCT:
			begin
				if (have_owed)
					req_o.kind = spw_char_pkg::FCT;
				if (have_credit)
					state_d = spw_link_pkg::RUN;
			end
			default:
			begin
				// Owed FCT beats data
				if (have_owed)
					req_o.kind = spw_char_pkg::FCT;
				else if (txwrite_i && have_credit)
					req_o.kind = nchar_kind;
			end
		endcase
		// Only offered while the shifter can take it
		req_o.valid = next_i && (state_q != spw_link_pkg::START);
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			state_q <= spw_link_pkg::START;
		else if (next_i)
			state_q <= state_d;
	end

endmodule

/* design/spw_tx_char_shifter.sv */
// Builds each character with its parity bit and shifts it out LSB-first, one bit per clock
`timescale 1ns/100ps

module spw_tx_char_shifter
(
	input  logic                    pclk_tx,
	input  logic                    enable_tx,
	input  spw_char_pkg::char_req_t req_i,
	output logic                    next_o,
	output logic                    line_bit_o,
	output logic                    active_o,
	output logic                    ready_o
);

	spw_char_pkg::char_word_t shift_q;
	spw_char_pkg::char_word_t load_word;
	spw_char_pkg::bit_cnt_t   cnt_q;
	spw_char_pkg::bit_cnt_t   load_len;
	logic [spw_char_pkg::MAX_CHAR_LEN-2:0] body;
	logic                     active_q;
	logic                     prev_par_q;
	logic                     dbits_par;
	logic                     parity;
	logic                     load;
	logic                     ready_q;

	// Last bit of a character, or idle
	assign next_o = !active_q || (cnt_q == spw_char_pkg::bit_cnt_t'(1));
	assign load   = next_o && req_i.valid;

	// --------------------
	// Character build
	// --------------------
	always_comb
	begin
		body      = '0;
		dbits_par = 1'b0;
		load_len  = spw_char_pkg::NULL_LEN;
		case (req_i.kind)
			spw_char_pkg::FCT:
			begin
				body[2:0] = spw_char_pkg::FCT_BITS;
				dbits_par = ^spw_char_pkg::FCT_BITS[2:1];
				load_len  = spw_char_pkg::FCT_LEN;
			end
			spw_char_pkg::EOP:
			begin
				body[2:0] = spw_char_pkg::EOP_BITS;
				dbits_par = ^spw_char_pkg::EOP_BITS[2:1];
				load_len  = spw_char_pkg::EOP_LEN;
			end
			spw_char_pkg::EEP:
			begin
				body[2:0] = spw_char_pkg::EEP_BITS;
				dbits_par = ^spw_char_pkg::EEP_BITS[2:1];
				load_len  = spw_char_pkg::EEP_LEN;
			end
			spw_char_pkg::DATA:
			begin
				body      = {req_i.data, spw_char_pkg::DATA_FLAG};
				dbits_par = ^req_i.data;
				load_len  = spw_char_pkg::DATA_LEN;
			end
			default:
			begin
				// Trailing FCT half of a NULL supplies the data bits
				body[6:0] = spw_char_pkg::NULL_BITS;
				dbits_par = ^spw_char_pkg::NULL_BITS[6:5];
			end
		endcase
		// Odd parity over previous data bits and this flag
		parity    = ~(prev_par_q ^ body[0]);
		load_word = {body, parity};
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			active_q   <= 1'b0;
			cnt_q      <= '0;
			prev_par_q <= 1'b0;
			ready_q    <= 1'b0;
		end
		else
		begin
			ready_q <= load && (req_i.kind != spw_char_pkg::NULL) &&
				(req_i.kind != spw_char_pkg::FCT);
			if (load)
			begin
				active_q   <= 1'b1;
				cnt_q      <= load_len;
				prev_par_q <= dbits_par;
			end
			else if (active_q)
			begin
				active_q <= !next_o;
				cnt_q    <= cnt_q - spw_char_pkg::bit_cnt_t'(1);
			end
		end
	end

	always_ff @(posedge pclk_tx)
	begin
		if (load)
			shift_q <= load_word;
		else if (active_q)
			shift_q <= shift_q >> 1;
	end

	assign line_bit_o = shift_q[0];
	assign active_o   = active_q;
	assign ready_o    = ready_q;

endmodule

/* design/spw_tx_ds_encoder.sv */
// Data-strobe line encoder, exactly one of the two lines changes per transmitted bit
`timescale 1ns/100ps

module spw_tx_ds_encoder
(
	input  logic                   pclk_tx,
	input  logic                   enable_tx,
	input  logic                   line_bit_i,
	input  logic                   active_i,
	output spw_link_pkg::ds_line_t line_o
);

	logic d_q;
	logic s_q;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			d_q <= 1'b0;
			s_q <= 1'b0;
		end
		else if (active_i)
		begin
			d_q <= line_bit_i;
			// Strobe moves when data does not
			if (line_bit_i == d_q)
				s_q <= ~s_q;
		end
	end

	assign line_o.d = d_q;
	assign line_o.s = s_q;

endmodule

/* design/spw_tx_top.sv */
// SpaceWire link transmitter top, connects flow control, link FSM, shifter and DS encoder
`timescale 1ns/100ps

module spw_tx_top
(
	input  logic                   pclk_tx,
	input  logic                   enable_tx,
	input  logic                   send_null_i,
	input  logic                   send_fct_i,
	input  logic                   gotfct_i,
	input  logic                   send_fct_now_i,
	input  logic                   txwrite_i,
	input  spw_char_pkg::tx_word_t data_i,
	output logic                   dout_o,
	output logic                   sout_o,
	output logic                   ready_o
);

	spw_char_pkg::char_req_t req;
	spw_link_pkg::credit_t   credit;
	spw_link_pkg::owed_t     owed;
	spw_link_pkg::ds_line_t  line;
	logic                    next;
	logic                    line_bit;
	logic                    active;

	spw_tx_credit u_credit
	(
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.gotfct_i       (gotfct_i),
		.send_fct_now_i (send_fct_now_i),
		.req_i          (req),
		.credit_o       (credit),
		.owed_o         (owed)
	);

	spw_tx_link_fsm u_link_fsm
	(
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.send_null_i (send_null_i),
		.send_fct_i  (send_fct_i),
		.txwrite_i   (txwrite_i),
		.data_i      (data_i),
		.next_i      (next),
		.credit_i    (credit),
		.owed_i      (owed),
		.req_o       (req)
	);

	spw_tx_char_shifter u_shifter
	(
		.pclk_tx    (pclk_tx),
		.enable_tx  (enable_tx),
		.req_i      (req),
		.next_o     (next),
		.line_bit_o (line_bit),
		.active_o   (active),
		.ready_o    (ready_o)
	);

	spw_tx_ds_encoder u_ds_encoder
	(
		.pclk_tx    (pclk_tx),
		.enable_tx  (enable_tx),
		.line_bit_i (line_bit),
		.active_i   (active),
		.line_o     (line)
	);

	assign dout_o = line.d;
	assign sout_o = line.s;

endmodule

/* dv/spw_tx_props.sv */
// Concurrent checks on the DS line pair and the shifter handshake, bound into the transmitter
`timescale 1ns/100ps

module spw_tx_line_props
(
	input logic                   pclk_tx,
	input logic                   enable_tx,
	input spw_link_pkg::ds_line_t line_i
);

	// Assertion failure tally
	int fail_cnt = 0;

	// Exactly one line may move per bit
	a_one_line_per_bit: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!((line_i.d != $past(line_i.d)) && (line_i.s != $past(line_i.s))))
	else
	begin
		$error("d and s changed in the same cycle");
		fail_cnt++;
	end

endmodule

module spw_tx_shift_props
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic ready_i,
	input logic load_i
);

	// Assertion failure tally
	int fail_cnt = 0;

	a_ready_one_cycle: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_i |=> !ready_i)
	else
	begin
		$error("ready pulse longer than one cycle");
		fail_cnt++;
	end

	// Shortest character is four bits long
	a_load_at_boundary: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		load_i |=> (!load_i) [*3])
	else
	begin
		$error("character loaded in the middle of another one");
		fail_cnt++;
	end

endmodule

bind spw_tx_char_shifter spw_tx_shift_props u_props
(
	.pclk_tx   (pclk_tx),
	.enable_tx (enable_tx),
	.ready_i   (ready_o),
	.load_i    (load)
);

bind spw_tx_ds_encoder spw_tx_line_props u_props
(
	.pclk_tx   (pclk_tx),
	.enable_tx (enable_tx),
	.line_i    (line_o)
);

/* dv/spw_tx_tb.sv */
// Trace-driven testbench for the SpaceWire transmitter, decodes the DS line and checks characters
`timescale 1ns/100ps

module spw_tx_tb;

	logic                   pclk_tx;
	logic                   enable_tx;
	logic                   send_null_i;
	logic                   send_fct_i;
	logic                   gotfct_i;
	logic                   send_fct_now_i;
	logic                   txwrite_i;
	spw_char_pkg::tx_word_t data_i;
	logic                   dout_o;
	logic                   sout_o;
	logic                   ready_o;

	// Parsed trace
	logic [63:0] op_q[$];
	logic [63:0] kind_q[$];
	logic [31:0] arg_q[$];
	int          cycle_limit = 0;
	int          cycle_cnt = 0;

	// Host side
	spw_char_pkg::tx_word_t host_q[$];
	int                     ready_cnt = 0;
	logic                   ready_seen = 1'b0;
	logic                   snull_given = 1'b0;

	// Line decoder state
	spw_char_pkg::char_req_t got_q[$];
	logic       d_prev = 1'b0;
	logic       s_prev = 1'b0;
	logic       line_started = 1'b0;
	logic       par_bit = 1'b0;
	logic       flag_bit = 1'b0;
	logic       esc_pending = 1'b0;
	logic       prev_dxor = 1'b0;
	logic       cur_dxor = 1'b0;
	logic [7:0] body_bits = '0;
	logic [7:0] first_bits = '0;
	int         bit_idx = 0;
	int         char_len = 0;
	int         bit_total = 0;
	int         char_total = 0;

	spw_tx_top u_dut
	(
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.send_null_i    (send_null_i),
		.send_fct_i     (send_fct_i),
		.gotfct_i       (gotfct_i),
		.send_fct_now_i (send_fct_now_i),
		.txwrite_i      (txwrite_i),
		.data_i         (data_i),
		.dout_o         (dout_o),
		.sout_o         (sout_o),
		.ready_o        (ready_o)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever
			#50 pclk_tx = ~pclk_tx;
	end

	// --------------------
	// Reporting
	// --------------------
	task automatic stop_failed(input string why);
		$display("Result: FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic report_error(input string why);
		$display("ERROR at %0t ns: %s", $time, why);
		stop_failed(why);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
			stop_failed("value mismatch");
		end
	endtask

	task automatic next_drive_point();
		@(posedge pclk_tx);
		#10;
	endtask

	function automatic logic [31:0] kind_code(input logic [63:0] kname);
		if (kname == "FCT")
			return spw_char_pkg::FCT;
		else if (kname == "DATA")
			return spw_char_pkg::DATA;
		else if (kname == "EOP")
			return spw_char_pkg::EOP;
		else if (kname == "EEP")
			return spw_char_pkg::EEP;
		else
			return 32'hffff_ffff;
	endfunction

	always @(negedge pclk_tx)
	begin
		if (u_dut.u_shifter.u_props.fail_cnt != 0 ||
			u_dut.u_ds_encoder.u_props.fail_cnt != 0)
			report_error("a bound assertion failed");
	end

	// --------------------
	// DS line decoder
	// --------------------
	task automatic finish_char();
		spw_char_pkg::char_req_t c;
		logic                    is_esc;
		c.valid = 1'b1;
		c.kind  = spw_char_pkg::DATA;
		c.data  = body_bits;
		is_esc  = 1'b0;
		if (flag_bit)
		begin
			// Control code bits in line order, first bit in bit 0
			c.data = '0;
			case (body_bits[1:0])
				2'b00: c.kind = spw_char_pkg::FCT;
				2'b10: c.kind = spw_char_pkg::EOP;
				2'b01: c.kind = spw_char_pkg::EEP;
				default: is_esc = 1'b1;
			endcase
		end
		if (esc_pending && (is_esc || c.kind != spw_char_pkg::FCT))
			report_error("ESC on the line not followed by FCT");
		else if (esc_pending)
		begin
			esc_pending = 1'b0;
			if (char_total == 0)
				check_eq("first NULL line bits", first_bits, 8'h2e);
			char_total++;
		end
		else if (is_esc)
			esc_pending = 1'b1;
		else
		begin
			if (char_total == 0)
				check_eq("first character kind", c.kind, spw_char_pkg::NULL);
			char_total++;
			got_q.push_back(c);
		end
	endtask

	task automatic take_bit(input logic b);
		logic par_exp;
		if (bit_total < 8)
			first_bits[bit_total] = b;
		bit_total++;
		if (bit_idx == 0)
		begin
			par_bit = b;
			bit_idx = 1;
		end
		else if (bit_idx == 1)
		begin
			// Odd over previous data bits, parity and flag
			flag_bit = b;
			par_exp  = ~(prev_dxor ^ b);
			check_eq("parity bit", par_bit, par_exp);
			char_len  = b ? 4 : 10;
			body_bits = '0;
			cur_dxor  = 1'b0;
			bit_idx   = 2;
		end
		else
		begin
			body_bits[bit_idx-2] = b;
			cur_dxor = cur_dxor ^ b;
			bit_idx++;
			if (bit_idx == char_len)
			begin
				prev_dxor = cur_dxor;
				bit_idx   = 0;
				finish_char();
			end
		end
	endtask

	always @(negedge pclk_tx)
	begin
		if (enable_tx)
		begin
			if (ready_o)
			begin
				ready_cnt++;
				ready_seen = 1'b1;
			end
			if (dout_o != d_prev && sout_o != s_prev)
				report_error("dout_o and sout_o changed in the same bit period");
			else if (dout_o != d_prev || sout_o != s_prev)
			begin
				if (!snull_given)
					report_error("DS line moved before send_null_i was raised");
				else
				begin
					line_started = 1'b1;
					take_bit(dout_o);
				end
			end
			else if (line_started)
				report_error("no DS transition in a bit period after link start");
			d_prev = dout_o;
			s_prev = sout_o;
		end
	end

	// --------------------
	// Host write port
	// --------------------
	initial
	begin : host_writer
		txwrite_i = 1'b0;
		data_i    = '0;
		forever
		begin
			next_drive_point();
			if (ready_seen && !txwrite_i)
				report_error("ready_o pulsed with no word offered");
			else if (ready_seen)
				void'(host_q.pop_front());
			ready_seen = 1'b0;
			if (host_q.size() != 0)
			begin
				data_i    = host_q[0];
				txwrite_i = 1'b1;
			end
			else
				txwrite_i = 1'b0;
		end
	end

	// --------------------
	// Trace handling
	// --------------------
	task automatic load_trace();
		int              fd;
		int              n;
		logic [8*128-1:0] text;
		logic [63:0]     op;
		logic [63:0]     kname;
		logic [31:0]     arg;
		fd = $fopen("dv/spw_tx_trace.txt", "r");
		if (fd == 0)
			report_error("trace file dv/spw_tx_trace.txt could not be opened");
		else
		begin
			while ($fgets(text, fd) != 0)
			begin
				op    = '0;
				kname = '0;
				arg   = '0;
				n = $sscanf(text, "%s", op);
				if (n == 1 && op != "#")
				begin
					if (op == "EXP")
						n = $sscanf(text, "%s %s %h", op, kname, arg);
					else if (op == "WRITE")
						n = $sscanf(text, "%s %h", op, arg);
					else
						n = $sscanf(text, "%s %d", op, arg);
					op_q.push_back(op);
					kind_q.push_back(kname);
					arg_q.push_back(arg);
				end
			end
			$fclose(fd);
			cycle_limit = 40 * op_q.size() + 200;
		end
	endtask

	task automatic run_step(input logic [63:0] op, input logic [63:0] kname,
		input logic [31:0] arg);
		spw_char_pkg::char_req_t c;
		if (op == "SNULL")
		begin
			send_null_i = 1'b1;
			snull_given = 1'b1;
		end
		else if (op == "SFCT")
			send_fct_i = 1'b1;
		else if (op == "GOTFCT")
		begin
			gotfct_i = 1'b1;
			next_drive_point();
			gotfct_i = 1'b0;
		end
		else if (op == "FCTNOW")
		begin
			send_fct_now_i = 1'b1;
			next_drive_point();
			send_fct_now_i = 1'b0;
		end
		else if (op == "WRITE")
			host_q.push_back(arg[8:0]);
		else if (op == "WAIT")
			repeat (arg) next_drive_point();
		else if (op == "READY")
			check_eq("ready_o pulse count", ready_cnt, arg);
		else if (op == "EXP" && kname == "NONE")
			check_eq("pending character count", got_q.size(), 0);
		else if (op == "EXP" && kind_code(kname) == 32'hffff_ffff)
			report_error("unknown character kind in trace");
		else if (op == "EXP")
		begin
			while (got_q.size() == 0)
				next_drive_point();
			c = got_q.pop_front();
			check_eq("character kind", c.kind, kind_code(kname));
			check_eq("character byte", c.data, arg[7:0]);
		end
		else
			report_error("unknown command in trace");
	endtask

	initial
	begin : cycle_guard
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit)
		begin
			@(posedge pclk_tx);
			cycle_cnt++;
		end
		report_error("timeout, trace did not finish within the cycle limit");
	end

	initial
	begin : run_trace
		int i;
		enable_tx      = 1'b0;
		send_null_i    = 1'b0;
		send_fct_i     = 1'b0;
		gotfct_i       = 1'b0;
		send_fct_now_i = 1'b0;
		load_trace();
		repeat (5)
		begin
			@(negedge pclk_tx);
			check_eq("dout_o", dout_o, 0);
			check_eq("sout_o", sout_o, 0);
			check_eq("ready_o", ready_o, 0);
		end
		next_drive_point();
		enable_tx = 1'b1;
		// Link stays silent until send_null_i
		repeat (20)
			next_drive_point();
		for (i = 0; i < op_q.size(); i++)
			run_step(op_q[i], kind_q[i], arg_q[i]);
		if (u_dut.u_shifter.u_props.fail_cnt == 0 &&
			u_dut.u_ds_encoder.u_props.fail_cnt == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
			report_error("bound assertions reported failures");
	end

endmodule

/* dv/spw_tx_trace.txt */
# Columns: command [argument], WRITE takes a hex host word, WAIT and READY decimal counts
# EXP kind [hex byte] expects the next non-NULL character, EXP NONE expects none pending
SNULL
WAIT 30
SFCT
EXP FCT
EXP FCT
EXP FCT
EXP FCT
EXP FCT
EXP FCT
EXP FCT
WRITE 0A5
WAIT 100
EXP NONE
READY 0
GOTFCT
WRITE 000
WRITE 0FF
WRITE 001
WRITE 080
WRITE 05A
WRITE 03C
WRITE 0C3
WRITE 07E
WRITE 011
WAIT 200
EXP DATA A5
EXP DATA 00
EXP DATA FF
EXP DATA 01
EXP DATA 80
EXP DATA 5A
EXP DATA 3C
EXP DATA C3
WAIT 60
EXP NONE
READY 8
GOTFCT
EXP DATA 7E
EXP DATA 11
READY 10
WRITE 100
WRITE 101
EXP EOP
EXP EEP
READY 12
FCTNOW
WRITE 033
EXP FCT
EXP DATA 33
WAIT 60
EXP NONE
READY 13

/* spw_tx_top.f */
design/spw_char_pkg.sv
design/spw_link_pkg.sv
design/spw_tx_credit.sv
design/spw_tx_link_fsm.sv
design/spw_tx_char_shifter.sv
design/spw_tx_ds_encoder.sv
design/spw_tx_top.sv
dv/spw_tx_props.sv
dv/spw_tx_tb.sv

/* Bender.yml */
package:
  name: spw_tx

sources:
  - design/spw_char_pkg.sv
  - design/spw_link_pkg.sv
  - design/spw_tx_credit.sv
  - design/spw_tx_link_fsm.sv
  - design/spw_tx_char_shifter.sv
  - design/spw_tx_ds_encoder.sv
  - design/spw_tx_top.sv
  - target: simulation
    files:
      - dv/spw_tx_props.sv
      - dv/spw_tx_tb.sv
